/* dw_quant_pkg.sv */
`default_nettype none

package dw_quant_pkg;

    typedef logic signed [7:0]  data_t;   // pixels, weights and pad value.
    typedef logic signed [31:0] acc_t;
    typedef logic signed [15:0] mul_t;
    typedef logic        [5:0]  shift_t;

    // nine weights of one channel, index 0 is the top left tap.
    typedef data_t [8:0] kernel_t;

    typedef struct packed {
        acc_t   bias;
        mul_t   mul;
        shift_t shift;
        data_t  relu_min;
        data_t  relu_max;
    } quant_t;

    typedef struct packed {
        logic  valid;
        logic  last;    // high on tap 8 of a pixel.
        data_t data;
    } tap_t;

    typedef struct packed {
        logic  valid;
        data_t data;
    } res_t;

endpackage

`default_nettype wire

/* conv_geom_pkg.sv */
`default_nettype none

package conv_geom_pkg;

    typedef logic        [15:0] dim_t;
    typedef logic signed [16:0] coord_t;  // negative where the tile starts in the padding.
    typedef logic        [31:0] addr_t;

    ////////////////////////////////////////////////////////////////////////
    // tile configuration, latched once per run.
    ////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        dim_t                in_img_h;
        dim_t                in_img_w;
        coord_t              tile_in_row;
        coord_t              tile_in_col;
        dim_t                tile_out_h;
        dim_t                tile_out_w;
        dim_t                channels;
        dim_t                stride;
        dw_quant_pkg::data_t pad_value;
        addr_t               in_base;
        addr_t               buf_base;
    } tile_cfg_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic                en;
        addr_t               addr;
        dw_quant_pkg::data_t data;
    } buf_wr_t;

endpackage

`default_nettype wire

/* dw_tile_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module dw_tile_seq (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       start_i,
    input  wire  conv_geom_pkg::dim_t channels_i,
    input  wire                       ch_done_i,
    output logic                      busy_o,
    output logic                      done_o,
    output logic                      cfg_load_o,
    output logic                      ch_start_o,
    output conv_geom_pkg::dim_t       ch_idx_o
);
    import conv_geom_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CH_SETUP,
        S_CH_RUN,
        S_DONE
    } state_t;

    state_t state;
    dim_t   last_ch;

    assign last_ch = channels_i - 1'b1;

    // S_DONE counts as idle from outside, so a new start may follow the done pulse.
    assign cfg_load_o = start_i && ((state == S_IDLE) || (state == S_DONE));
    assign busy_o     = (state == S_CH_SETUP) || (state == S_CH_RUN);
    assign done_o     = (state == S_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            ch_start_o <= 1'b0;
            ch_idx_o   <= '0;
        end else begin
            ch_start_o <= 1'b0;
            case (state)
                S_IDLE, S_DONE: begin
                    state <= S_IDLE;
                    if (start_i) begin
                        ch_idx_o <= '0;
                        state    <= S_CH_SETUP;
                    end
                end
                S_CH_SETUP: begin
                    // the index has been stable for a cycle by now.
                    ch_start_o <= 1'b1;
                    state      <= S_CH_RUN;
                end
                S_CH_RUN: begin
                    if (ch_done_i) begin
                        if (ch_idx_o == last_ch) begin
                            state <= S_DONE;
                        end else begin
                            ch_idx_o <= ch_idx_o + 1'b1;
                            state    <= S_CH_SETUP;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* dw_tap_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module dw_tap_fetch (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             ch_start_i,
    input  wire  conv_geom_pkg::dim_t       ch_idx_i,
    input  wire  conv_geom_pkg::tile_cfg_t  cfg_i,
    output conv_geom_pkg::mem_rd_req_t      in_rd_o,
    input  wire  dw_quant_pkg::data_t       in_rd_data_i,
    output dw_quant_pkg::tap_t              tap_o
);
    import conv_geom_pkg::*;
    import dw_quant_pkg::*;

    logic       active;
    dim_t       oy;
    dim_t       ox;
    logic [1:0] ky;
    logic [1:0] kx;
    coord_t     row_base;   // input row of tap (0, x) for the current pixel.
    coord_t     col_base;
    coord_t     step;
    coord_t     row;
    coord_t     col;
    addr_t      plane_base;
    logic       pad;
    logic       tap_end;

    logic       side_valid;
    logic       side_last;
    logic       side_pad;
    data_t      side_pad_val;

    assign step    = coord_t'(cfg_i.stride);
    assign row     = row_base + coord_t'(ky);
    assign col     = col_base + coord_t'(kx);
    assign tap_end = (ky == 2'd2) && (kx == 2'd2);

    // the sign bit covers the top and left border, the compare covers the other two.
    assign pad = row[16] || col[16] || (row[15:0] >= cfg_i.in_img_h) ||
                 (col[15:0] >= cfg_i.in_img_w);

    always_comb begin
        in_rd_o.en   = active && !pad;   // a pad tap still takes its cycle.
        in_rd_o.addr = plane_base + addr_t'(row[15:0]) * addr_t'(cfg_i.in_img_w) +
                       addr_t'(col[15:0]);
    end

    ////////////////////////////////////////////////////////////////////////
    // pixel and kernel walk, one tap per cycle.
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active     <= 1'b0;
            oy         <= '0;
            ox         <= '0;
            ky         <= '0;
            kx         <= '0;
            row_base   <= '0;
            col_base   <= '0;
            plane_base <= '0;
        end else if (ch_start_i) begin
            active     <= 1'b1;
            oy         <= '0;
            ox         <= '0;
            ky         <= '0;
            kx         <= '0;
            row_base   <= cfg_i.tile_in_row;
            col_base   <= cfg_i.tile_in_col;
            plane_base <= cfg_i.in_base +
                          addr_t'(ch_idx_i) * addr_t'(cfg_i.in_img_h) * addr_t'(cfg_i.in_img_w);
        end else if (active) begin
            if (kx != 2'd2) begin
                kx <= kx + 2'd1;
            end else begin
                kx <= '0;
                if (ky != 2'd2) begin
                    ky <= ky + 2'd1;
                end else begin
                    ky <= '0;
                    if (ox != cfg_i.tile_out_w - 1'b1) begin
                        ox       <= ox + 1'b1;
                        col_base <= col_base + step;
                    end else begin
                        ox       <= '0;
                        col_base <= cfg_i.tile_in_col;
                        if (oy != cfg_i.tile_out_h - 1'b1) begin
                            oy       <= oy + 1'b1;
                            row_base <= row_base + step;
                        end else begin
                            active <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    // travels beside the one cycle of memory latency.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            side_valid   <= 1'b0;
            side_last    <= 1'b0;
            side_pad     <= 1'b0;
            side_pad_val <= '0;
        end else begin
            side_valid   <= active;
            side_last    <= active && tap_end;
            side_pad     <= pad;
            side_pad_val <= cfg_i.pad_value;
        end
    end

    always_comb begin
        tap_o.valid = side_valid;
        tap_o.last  = side_last;
        tap_o.data  = side_pad ? side_pad_val : in_rd_data_i;
    end

endmodule

`default_nettype wire

/* dw_mac_requant.sv */
`timescale 1ns/1ps
`default_nettype none

module dw_mac_requant (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  dw_quant_pkg::tap_t    tap_i,
    input  wire  dw_quant_pkg::kernel_t kernel_i,
    input  wire  dw_quant_pkg::quant_t  quant_i,
    output dw_quant_pkg::res_t          res_o
);
    import dw_quant_pkg::*;

    logic [3:0]         tap_cnt;
    data_t              weight;
    logic signed [15:0] prod;
    acc_t               acc;
    acc_t               acc_next;
    logic               sum_valid;  // acc holds a finished pixel sum.
    logic signed [47:0] scaled;
    logic signed [47:0] shifted;
    data_t              clamped;

    ////////////////////////////////////////////////////////////////////////
    // accumulate stage
    ////////////////////////////////////////////////////////////////////////
    assign weight   = kernel_i[tap_cnt];
    assign prod     = tap_i.data * weight;
    assign acc_next = ((tap_cnt == 4'd0) ? quant_i.bias : acc) + acc_t'(prod);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap_cnt   <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= tap_i.valid && tap_i.last;
            if (tap_i.valid) begin
                tap_cnt <= tap_i.last ? 4'd0 : tap_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tap_i.valid) begin
            acc <= acc_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // requantize stage
    ////////////////////////////////////////////////////////////////////////
    assign scaled  = acc * quant_i.mul;
    assign shifted = scaled >>> quant_i.shift;   // floors negative values.

    always_comb begin
        if (shifted > quant_i.relu_max) begin
            clamped = quant_i.relu_max;
        end else if (shifted < quant_i.relu_min) begin
            clamped = quant_i.relu_min;
        end else begin
            clamped = shifted[7:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_o <= '0;
        end else begin
            res_o.valid <= sum_valid;
            res_o.data  <= clamped;
        end
    end

endmodule

`default_nettype wire

/* dw_buf_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module dw_buf_writer (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            ch_start_i,
    input  wire  conv_geom_pkg::dim_t      ch_idx_i,
    input  wire  conv_geom_pkg::tile_cfg_t cfg_i,
    input  wire  dw_quant_pkg::res_t       res_i,
    output conv_geom_pkg::buf_wr_t         buf_wr_o,
    output logic                           ch_done_o
);
    import conv_geom_pkg::*;

    addr_t ch_base;
    addr_t pix_cnt;
    addr_t pix_total;

    assign pix_total = addr_t'(cfg_i.tile_out_h) * addr_t'(cfg_i.tile_out_w);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch_base   <= '0;
            pix_cnt   <= '0;
            buf_wr_o  <= '0;
            ch_done_o <= 1'b0;
        end else begin
            buf_wr_o.en <= 1'b0;
            ch_done_o   <= 1'b0;
            if (ch_start_i) begin
                ch_base <= cfg_i.buf_base + addr_t'(ch_idx_i) * pix_total;
                pix_cnt <= '0;
            end else if (res_i.valid) begin
                buf_wr_o.en   <= 1'b1;
                buf_wr_o.addr <= ch_base + pix_cnt;  // pixels arrive row-major.
                buf_wr_o.data <= res_i.data;
                pix_cnt       <= pix_cnt + 1'b1;
                ch_done_o     <= (pix_cnt == pix_total - 1'b1);
            end
        end
    end

endmodule

`default_nettype wire

/* dw_tile_runner.sv */
`timescale 1ns/1ps
`default_nettype none

module dw_tile_runner (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            start_i,
    output logic                           busy_o,
    output logic                           done_o,
    input  wire  conv_geom_pkg::tile_cfg_t cfg_i,
    output conv_geom_pkg::mem_rd_req_t     in_rd_o,
    input  wire  dw_quant_pkg::data_t      in_rd_data_i,
    output conv_geom_pkg::buf_wr_t         buf_wr_o,
    input  wire  dw_quant_pkg::kernel_t    kernel_i,
    input  wire  dw_quant_pkg::quant_t     quant_i,
    output conv_geom_pkg::dim_t            ch_idx_o
);
    import conv_geom_pkg::*;
    import dw_quant_pkg::*;

    tile_cfg_t cfg_q;       // held for the whole run.
    logic      cfg_load;
    logic      ch_start;
    logic      ch_done;
    tap_t      tap;
    res_t      res;

    always_ff @(posedge clk) begin
        if (cfg_load) begin
            cfg_q <= cfg_i;
        end
    end

    dw_tile_seq u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .channels_i (cfg_q.channels),
        .ch_done_i  (ch_done),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .cfg_load_o (cfg_load),
        .ch_start_o (ch_start),
        .ch_idx_o   (ch_idx_o)
    );

    dw_tap_fetch u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .ch_start_i   (ch_start),
        .ch_idx_i     (ch_idx_o),
        .cfg_i        (cfg_q),
        .in_rd_o      (in_rd_o),
        .in_rd_data_i (in_rd_data_i),
        .tap_o        (tap)
    );

    dw_mac_requant u_mac (
        .clk      (clk),
        .rst_n    (rst_n),
        .tap_i    (tap),
        .kernel_i (kernel_i),
        .quant_i  (quant_i),
        .res_o    (res)
    );

    dw_buf_writer u_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .ch_start_i (ch_start),
        .ch_idx_i   (ch_idx_o),
        .cfg_i      (cfg_q),
        .res_i      (res),
        .buf_wr_o   (buf_wr_o),
        .ch_done_o  (ch_done)
    );

endmodule

`default_nettype wire

/* tb_dw_tile_runner.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dw_tile_runner;
    import conv_geom_pkg::*;
    import dw_quant_pkg::*;

    localparam int MEM_SIZE = 1024;
    localparam int MAX_CH   = 4;
    localparam int N_TESTS  = 6;

    logic        clk;
    logic        rst_n;
    logic        start_i;
    logic        busy_o;
    logic        done_o;
    tile_cfg_t   cfg_i;
    mem_rd_req_t in_rd_o;
    data_t       in_rd_data_i;
    buf_wr_t     buf_wr_o;
    kernel_t     kernel_i;
    quant_t      quant_i;
    dim_t        ch_idx_o;

    integer      seed = 32'h0e384c4f;
    data_t       mem [0:MEM_SIZE-1];
    kernel_t     kern_tab [0:MAX_CH-1];
    quant_t      quant_tab [0:MAX_CH-1];
    tile_cfg_t   cfg_list [0:N_TESTS-1];
    tile_cfg_t   cur_cfg;
    string       test_name;
    logic        run_active = 1'b0;
    int          exp_total;
    int          wr_count = 0;
    logic        wr_prev = 1'b0;   // a buffer write was seen in the previous cycle.
    int          done_cnt = 0;
    int          exp_ch;
    int          exp_oy;
    int          exp_ox;
    logic        rd_en_q = 1'b0;
    addr_t       rd_addr_q;
    int          budget_cycles;
    logic        budget_ready = 1'b0;

    dw_tile_runner dw_tile_runner_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .cfg_i        (cfg_i),
        .in_rd_o      (in_rd_o),
        .in_rd_data_i (in_rd_data_i),
        .buf_wr_o     (buf_wr_o),
        .kernel_i     (kernel_i),
        .quant_i      (quant_i),
        .ch_idx_o     (ch_idx_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            fail_run($sformatf("FAILED %s: address expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            fail_run($sformatf("FAILED %s: data expected %0d, actual %0d", name, exp, act));
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // expected pixel from the tap and requantization rules.
    ////////////////////////////////////////////////////////////////////
    function automatic data_t ref_pixel(input int ch, input int oy, input int ox);
        int     row;
        int     col;
        int     h;
        int     w;
        int     acc;
        longint scaled;
        data_t  tap;
        h   = int'(cur_cfg.in_img_h);
        w   = int'(cur_cfg.in_img_w);
        acc = int'(quant_tab[ch].bias);
        for (int ky = 0; ky < 3; ky++) begin
            for (int kx = 0; kx < 3; kx++) begin
                row = int'(cur_cfg.tile_in_row) + oy * int'(cur_cfg.stride) + ky;
                col = int'(cur_cfg.tile_in_col) + ox * int'(cur_cfg.stride) + kx;
                if (row < 0 || row >= h || col < 0 || col >= w) begin
                    tap = cur_cfg.pad_value;
                end else begin
                    tap = mem[int'(cur_cfg.in_base) + ch * h * w + row * w + col];
                end
                acc = acc + int'(tap) * int'(kern_tab[ch][ky * 3 + kx]);
            end
        end
        scaled = longint'(acc) * longint'(quant_tab[ch].mul);
        scaled = scaled >>> quant_tab[ch].shift;   // the shift floors negative sums.
        if (scaled > longint'(quant_tab[ch].relu_max)) begin
            scaled = longint'(quant_tab[ch].relu_max);
        end else if (scaled < longint'(quant_tab[ch].relu_min)) begin
            scaled = longint'(quant_tab[ch].relu_min);
        end
        return data_t'(scaled);
    endfunction

    function automatic tile_cfg_t make_cfg(input int h, input int w, input int row,
                                           input int col, input int oh, input int ow,
                                           input int ch, input int stride, input int pad,
                                           input int in_base, input int buf_base);
        tile_cfg_t c;
        c             = '0;
        c.in_img_h    = dim_t'(h);
        c.in_img_w    = dim_t'(w);
        c.tile_in_row = coord_t'(row);
        c.tile_in_col = coord_t'(col);
        c.tile_out_h  = dim_t'(oh);
        c.tile_out_w  = dim_t'(ow);
        c.channels    = dim_t'(ch);
        c.stride      = dim_t'(stride);
        c.pad_value   = data_t'(pad);
        c.in_base     = addr_t'(in_base);
        c.buf_base    = addr_t'(buf_base);
        return c;
    endfunction

    task automatic fill_tables(input bit clamp);
        data_t a;
        data_t b;
        for (int ch = 0; ch < MAX_CH; ch++) begin
            for (int k = 0; k < 9; k++) begin
                kern_tab[ch][k] = clamp ? 8'sd127 : data_t'($random(seed));
            end
            a = data_t'($random(seed));
            b = data_t'($random(seed));
            quant_tab[ch].bias     = acc_t'($random(seed) % 1024);
            quant_tab[ch].mul      = clamp ? 16'sd600 : mul_t'($random(seed) % 128);
            quant_tab[ch].shift    = clamp ? 6'd0 : shift_t'($unsigned($random(seed)) % 13);
            quant_tab[ch].relu_min = clamp ? -8'sd20 : ((a < b) ? a : b);
            quant_tab[ch].relu_max = clamp ? 8'sd40 : ((a < b) ? b : a);
        end
    endtask

    // the input memory answers one cycle after the request and the coefficients follow ch_idx_o.
    always @(negedge clk) begin
        rd_en_q   = in_rd_o.en;
        rd_addr_q = in_rd_o.addr;
        if (in_rd_o.en === 1'b1 && in_rd_o.addr >= MEM_SIZE) begin
            fail_run("input read addressed outside the memory model");
        end
    end

    always @(posedge clk) begin
        #2;
        if (rd_en_q) begin
            in_rd_data_i = mem[rd_addr_q];
        end
        kernel_i = kern_tab[ch_idx_o];
        quant_i  = quant_tab[ch_idx_o];
    end

    ////////////////////////////////////////////////////////////////////
    // buffer writes are compared in row-major order per channel.
    ////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (done_o === 1'b1) begin
            if (!run_active) begin
                fail_run("done_o pulsed while no run was active");
            end
            if (!wr_prev || wr_count != exp_total || busy_o !== 1'b0) begin
                fail_run($sformatf("%s: done_o did not follow the last write with busy_o low",
                                   test_name));
            end
            done_cnt = done_cnt + 1;
        end
        if (buf_wr_o.en === 1'b1) begin
            if (!run_active) begin
                fail_run("a buffer write arrived while no run was active");
            end
            if (wr_count >= exp_total) begin
                fail_run($sformatf("%s: more buffer writes than expected", test_name));
            end
            check_addr(test_name, cur_cfg.buf_base + addr_t'(exp_ch * int'(cur_cfg.tile_out_h)
                       * int'(cur_cfg.tile_out_w) + exp_oy * int'(cur_cfg.tile_out_w) + exp_ox),
                       buf_wr_o.addr);
            check_data(test_name, ref_pixel(exp_ch, exp_oy, exp_ox), buf_wr_o.data);
            wr_count = wr_count + 1;
            exp_ox   = exp_ox + 1;
            if (exp_ox == int'(cur_cfg.tile_out_w)) begin
                exp_ox = 0;
                exp_oy = exp_oy + 1;
                if (exp_oy == int'(cur_cfg.tile_out_h)) begin
                    exp_oy = 0;
                    exp_ch = exp_ch + 1;
                end
            end
        end
        wr_prev = (buf_wr_o.en === 1'b1);
    end

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (busy_o !== 1'b0 || done_o !== 1'b0 || in_rd_o.en !== 1'b0 ||
                buf_wr_o.en !== 1'b0 || ch_idx_o !== '0) begin
                fail_run("busy, done, an enable or ch_idx_o is not in its reset state before start");
            end
        end
    endtask

    task automatic run_test(input string name, input tile_cfg_t cfg, input bit extra_start);
        tile_cfg_t other;
        test_name  = name;
        cur_cfg    = cfg;
        exp_total  = int'(cfg.channels) * int'(cfg.tile_out_h) * int'(cfg.tile_out_w);
        wr_count   = 0;
        done_cnt   = 0;
        exp_ch     = 0;
        exp_oy     = 0;
        exp_ox     = 0;
        run_active = 1'b1;
        other          = cfg;
        other.buf_base = cfg.buf_base + 32'h400;   // a wrong latch shows in the addresses.
        other.channels = 16'd1;
        @(posedge clk);
        #2;
        cfg_i   = cfg;
        start_i = 1'b1;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        cfg_i   = other;
        @(negedge clk);
        if (busy_o !== 1'b1) begin
            fail_run($sformatf("%s: busy_o did not rise after start", name));
        end
        if (extra_start) begin
            repeat (20) @(posedge clk);
            #2;
            start_i = 1'b1;
            @(posedge clk);
            #2;
            start_i = 1'b0;
        end
        wait (done_cnt > 0);
        repeat (6) @(negedge clk);
        if (wr_count != exp_total) begin
            fail_run($sformatf("%s: %0d buffer writes seen, %0d expected",
                               name, wr_count, exp_total));
        end
        if (done_cnt != 1) begin
            fail_run($sformatf("%s: done_o pulsed %0d times instead of once", name, done_cnt));
        end
        if (busy_o !== 1'b0) begin
            fail_run($sformatf("%s: busy_o still high after done_o", name));
        end
        run_active = 1'b0;
    endtask

    // the watchdog allows 12 cycles per tap plus 100 per test.
    initial begin
        wait (budget_ready);
        repeat (budget_cycles) @(posedge clk);
        fail_run($sformatf("watchdog expired after %0d cycles", budget_cycles));
    end

    initial begin
        rst_n        = 1'b0;
        start_i      = 1'b0;
        cfg_i        = '0;
        in_rd_data_i = '0;
        kernel_i     = '0;
        quant_i      = '0;
        for (int i = 0; i < MEM_SIZE; i++) begin
            mem[i] = data_t'($random(seed));
        end
        fill_tables(1'b0);
        cfg_list[0] = make_cfg(8, 8, 2, 1, 4, 5, 3, 1, 0, 'h040, 'h1000);
        cfg_list[1] = make_cfg(6, 7, -1, -1, 6, 7, 2, 1, -37, 'h080, 'h2000);
        cfg_list[2] = make_cfg(10, 9, 1, 0, 4, 3, 2, 2, 0, 'h100, 'h3000);
        cfg_list[3] = make_cfg(8, 8, 1, 1, 3, 3, 2, 1, 0, 'h200, 'h4000);
        cfg_list[4] = make_cfg(7, 6, 0, 0, 5, 4, 2, 1, -5, 'h280, 'h5000);
        cfg_list[5] = make_cfg(5, 5, -1, 0, 4, 3, 3, 1, 9, 'h300, 'h6000);
        budget_cycles = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            budget_cycles = budget_cycles + 100 + 12 * 9 * int'(cfg_list[t].channels) *
                            int'(cfg_list[t].tile_out_h) * int'(cfg_list[t].tile_out_w);
        end
        budget_ready = 1'b1;

        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        expect_idle(8);

        run_test("interior", cfg_list[0], 1'b0);
        fill_tables(1'b0);
        run_test("padding", cfg_list[1], 1'b0);
        fill_tables(1'b0);
        run_test("stride2", cfg_list[2], 1'b0);
        fill_tables(1'b1);
        run_test("clamp", cfg_list[3], 1'b0);
        fill_tables(1'b0);
        run_test("busy_start", cfg_list[4], 1'b1);
        run_test("restart", cfg_list[5], 1'b0);

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
dw_quant_pkg.sv
conv_geom_pkg.sv
dw_tile_seq.sv
dw_tap_fetch.sv
dw_mac_requant.sv
dw_buf_writer.sv
dw_tile_runner.sv
tb_dw_tile_runner.sv
